// ==== verilog/quant_settings.svh ====
`ifndef QUANT_SETTINGS_SVH
`define QUANT_SETTINGS_SVH

// number of 32-bit columns in one input beat
`define QUANT_COLS 16

// width of one column of the input beat
`define QUANT_COL_WIDTH 32

// width of one integer lane, and also of the float held in a column's low half
`define QUANT_LANE_WIDTH 16

// two integer lanes per column
`define QUANT_LANES 32

// input beat from the write-back buffer, output beat towards the stream sink
`define QUANT_IN_WIDTH 512
`define QUANT_OUT_WIDTH 256

// register stages between a scaler operand and its 8-bit result
`define QUANT_SCALE_LAT 2

`endif

// ==== verilog/quant_pkg.sv ====
`include "quant_settings.svh"

package quant_pkg;

    // whole beats on either side of the quantizer
    typedef logic [`QUANT_IN_WIDTH-1:0] in_beat_t;
    typedef logic [`QUANT_OUT_WIDTH-1:0] out_beat_t;

    // one integer partial sum and one half-precision float
    typedef logic signed [`QUANT_LANE_WIDTH-1:0] psum_t;
    typedef logic [`QUANT_LANE_WIDTH-1:0] fp16_t;

    // shared scaling factor, mantissa times 2^-exp
    typedef logic [15:0] sf_man_t;
    typedef logic [4:0] sf_exp_t;

    // float mantissa with its hidden one, in two's complement
    typedef logic signed [8:0] lane_man_t;

    // a signed 16-bit operand times a 16-bit unsigned mantissa needs 33 bits
    typedef logic signed [32:0] prod_t;

    typedef logic signed [7:0] qbyte_t;

    // int8 to fp16 has no datapath here, so its output stays silent
    typedef enum logic [1:0] {
        mode_int8_int8 = 2'b00,
        mode_int8_fp16 = 2'b01,
        mode_fp16_int8 = 2'b10,
        mode_fp16_fp16 = 2'b11
    } quant_mode_t;

endpackage

// ==== verilog/lane_scaler.sv ====
`timescale 1ns/1ps

module lane_scaler (
    input  logic               clk,
    input  quant_pkg::psum_t   int_lane,
    input  quant_pkg::fp16_t   float_lane,
    input  logic               use_float,
    input  quant_pkg::sf_man_t sf_man,
    input  quant_pkg::sf_exp_t sf_exp,
    output quant_pkg::qbyte_t  result
);
    import quant_pkg::*;

    lane_man_t float_mag;
    lane_man_t float_man;
    psum_t     operand;
    prod_t     product;
    prod_t     shifted;

    // the float mantissa is sign-magnitude with a hidden one above bits 6:0
    assign float_mag = {2'b01, float_lane[6:0]};

    // the exponent field is ignored here since the host folds it into sf_exp
    assign float_man = float_lane[$bits(fp16_t)-1] ? -float_mag : float_mag;

    // widen the float mantissa to the integer lane width
    assign operand = use_float
                   ? {{($bits(psum_t) - $bits(lane_man_t)){float_man[$bits(lane_man_t)-1]}},
                      float_man}
                   : int_lane;

    // first stage, signed operand times the unsigned scale mantissa
    always_ff @(posedge clk) begin
        product <= operand * $signed({1'b0, sf_man});
    end

    // arithmetic shift keeps the sign of negative products
    assign shifted = product >>> sf_exp;

    // second stage, plain truncation to the low byte with no saturation
    always_ff @(posedge clk) begin
        result <= shifted[$bits(qbyte_t)-1:0];
    end

endmodule

// ==== verilog/scale_array.sv ====
`timescale 1ns/1ps

`include "quant_settings.svh"

module scale_array (
    input  logic                   clk,
    input  quant_pkg::in_beat_t    in_data,
    input  quant_pkg::quant_mode_t quant_mode,
    input  quant_pkg::sf_man_t     sf_man,
    input  quant_pkg::sf_exp_t     sf_exp,
    output quant_pkg::out_beat_t   scaled_data
);
    import quant_pkg::*;

    localparam int BYTE_W = $bits(qbyte_t);
    localparam int HALF_W = `QUANT_OUT_WIDTH / 2;

    logic                          use_float;
    logic [`QUANT_SCALE_LAT-1:0]   float_pipe;
    logic [`QUANT_OUT_WIDTH-1:0]   lane_bytes;
    logic [HALF_W-1:0]             col_bytes;

    // only fp16 to int8 reads float lanes, the other modes read integers
    assign use_float = (quant_mode == mode_fp16_int8);

    // lane k sits at bits 16k+15:16k, so lane 2c is column c's low half,
    // which is also where that column's float lives
    for (genvar k = 0; k < `QUANT_LANES; k++) begin : g_lane
        fp16_t  lane_float;
        logic   lane_use_float;
        qbyte_t lane_result;

        if (k % 2 == 0) begin : g_even
            assign lane_float     = in_data[k*`QUANT_LANE_WIDTH +: `QUANT_LANE_WIDTH];
            assign lane_use_float = use_float;
            // column k/2 result for the fp16 packing
            assign col_bytes[(k/2)*BYTE_W +: BYTE_W] = lane_result;
        end else begin : g_odd
            assign lane_float     = '0;
            assign lane_use_float = 1'b0;
        end

        lane_scaler u_scaler (
            .clk       (clk),
            .int_lane  (in_data[k*`QUANT_LANE_WIDTH +: `QUANT_LANE_WIDTH]),
            .float_lane(lane_float),
            .use_float (lane_use_float),
            .sf_man    (sf_man),
            .sf_exp    (sf_exp),
            .result    (lane_result)
        );

        assign lane_bytes[k*BYTE_W +: BYTE_W] = lane_result;
    end

    // the packing choice travels with the lane pipeline so it lines up
    // with the results of the scaler's last stage
    always_ff @(posedge clk) begin
        float_pipe <= {float_pipe[`QUANT_SCALE_LAT-2:0], use_float};
    end

    // fp16 to int8 fills only the low half with one byte per column
    assign scaled_data = float_pipe[`QUANT_SCALE_LAT-1]
                       ? {{HALF_W{1'b0}}, col_bytes}
                       : lane_bytes;

endmodule

// ==== verilog/quant_output_stage.sv ====
`timescale 1ns/1ps

`include "quant_settings.svh"

module quant_output_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  quant_pkg::quant_mode_t quant_mode,
    input  quant_pkg::in_beat_t    in_data,
    input  logic                   in_valid,
    input  logic                   in_last,
    input  quant_pkg::out_beat_t   scaled_data,
    output quant_pkg::out_beat_t   out_data,
    output logic                   out_valid,
    output logic                   out_last
);
    import quant_pkg::*;

    logic [`QUANT_SCALE_LAT-1:0] valid_dly;
    logic [`QUANT_SCALE_LAT-1:0] last_dly;
    out_beat_t                   pass_data;
    logic                        scaled_valid;
    logic                        scaled_last;

    // valid and last follow the scaler pipeline so they meet their data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_dly <= '0;
            last_dly  <= '0;
        end else begin
            valid_dly <= {valid_dly[`QUANT_SCALE_LAT-2:0], in_valid};
            last_dly  <= {last_dly[`QUANT_SCALE_LAT-2:0], in_last};
        end
    end

    assign scaled_valid = valid_dly[`QUANT_SCALE_LAT-1];
    assign scaled_last  = last_dly[`QUANT_SCALE_LAT-1];

    // fp16 pass-through keeps the low half of every column,
    // column c lands at bits 16c+15:16c
    for (genvar c = 0; c < `QUANT_COLS; c++) begin : g_pass
        assign pass_data[c*`QUANT_LANE_WIDTH +: `QUANT_LANE_WIDTH] =
            in_data[c*`QUANT_COL_WIDTH +: `QUANT_LANE_WIDTH];
    end

    // the flags of the output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            case (quant_mode)
                mode_int8_int8, mode_fp16_int8: begin
                    out_valid <= scaled_valid;
                    out_last  <= scaled_last;
                end
                mode_fp16_fp16: begin
                    out_valid <= in_valid;
                    out_last  <= in_last;
                end
                default: begin
                    // int8 to fp16 produces nothing
                    out_valid <= 1'b0;
                    out_last  <= 1'b0;
                end
            endcase
        end
    end

    // the data half of the output register
    always_ff @(posedge clk) begin
        case (quant_mode)
            mode_int8_int8, mode_fp16_int8: out_data <= scaled_data;
            mode_fp16_fp16:                 out_data <= pass_data;
            default:                        out_data <= '0;
        endcase
    end

endmodule

// ==== verilog/dm_quant_top.sv ====
`timescale 1ns/1ps

module dm_quant_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  quant_pkg::sf_exp_t     sf_exp,
    input  quant_pkg::sf_man_t     sf_man,
    input  quant_pkg::quant_mode_t quant_mode,
    input  quant_pkg::in_beat_t    in_data,
    input  logic                   in_valid,
    input  logic                   in_last,
    output quant_pkg::out_beat_t   out_data,
    output logic                   out_valid,
    output logic                   out_last
);
    import quant_pkg::*;

    // int8 results of the scaler array, already packed for the mode
    out_beat_t scaled_data;

    // scaling path, two cycles with no control of its own
    scale_array u_scale_array (
        .clk        (clk),
        .in_data    (in_data),
        .quant_mode (quant_mode),
        .sf_man     (sf_man),
        .sf_exp     (sf_exp),
        .scaled_data(scaled_data)
    );

    // delay lines, fp16 pass-through and the registered output mux
    quant_output_stage u_output_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .quant_mode (quant_mode),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .scaled_data(scaled_data),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_last   (out_last)
    );

endmodule

// ==== tb/quant_checker.sv ====
`timescale 1ns/1ps

module quant_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  quant_pkg::out_beat_t out_data,
    input  logic                 out_valid,
    input  logic                 out_last,
    input  logic [3:0]           cur_test,
    input  logic                 report_now,
    output int                   beats_expected,
    output int                   beats_seen,
    output int                   error_count
);
    import quant_pkg::*;

    localparam int REC_WORDS = 7;
    localparam int MAX_RECS  = 64;
    localparam int NUM_TESTS = 6;

    logic [127:0] vec_mem [0:REC_WORDS*MAX_RECS-1];
    out_beat_t    exp_data_q[$];
    logic         exp_last_q[$];
    int           exp_test_q[$];
    int           exp_cycle_q[$];
    int           test_expected[0:NUM_TESTS];
    int           test_seen[0:NUM_TESTS];
    int           test_errors[0:NUM_TESTS];
    string        test_name[0:NUM_TESTS];
    int           n_expected = 0;
    int           n_seen = 0;
    int           n_errors = 0;
    int           cycle_count = 0;
    out_beat_t    exp_data;
    logic         exp_last;
    int           exp_test;
    int           exp_cycle;
    logic [127:0] ctrl;

    assign beats_expected = n_expected;
    assign beats_seen     = n_seen;
    assign error_count    = n_errors;

    // collect the expected output beats, in order, from the driven lines
    initial begin
        test_name[1] = "idle after reset";
        test_name[2] = "int8 to int8 scaling";
        test_name[3] = "fp16 to int8 scaling";
        test_name[4] = "fp16 pass-through";
        test_name[5] = "back-to-back beats";
        test_name[6] = "dropped mode";
        for (int t = 0; t <= NUM_TESTS; t++) begin
            test_expected[t] = 0;
            test_seen[t]     = 0;
            test_errors[t]   = 0;
        end
        $readmemh("tb/quant_vectors.txt", vec_mem);
        for (int r = 0; r < MAX_RECS; r++) begin
            ctrl = vec_mem[r*REC_WORDS];
            if (ctrl[39:36] == 4'd0) begin
                break;
            end
            // mode 01 has no datapath, so its beats never come out
            if (ctrl[4] && ctrl[33:32] != 2'b01) begin
                exp_data_q.push_back({vec_mem[r*REC_WORDS+5], vec_mem[r*REC_WORDS+6]});
                exp_last_q.push_back(ctrl[0]);
                exp_test_q.push_back(int'(ctrl[39:36]));
                // record r is driven at cycle r and its beat is on the output 3 cycles later,
                // or 1 in fp16 pass-through, so it is sampled here one cycle after that
                exp_cycle_q.push_back(r + ((ctrl[33:32] == 2'b11) ? 2 : 4));
                test_expected[int'(ctrl[39:36])]++;
                n_expected++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                if (exp_data_q.size() == 0 || exp_cycle_q[0] > cycle_count) begin
                    $display("unexpected output beat at cycle %0d during test %0d",
                             cycle_count, cur_test);
                    n_errors++;
                    test_errors[int'(cur_test)]++;
                end else begin
                    exp_data = exp_data_q.pop_front();
                    exp_last = exp_last_q.pop_front();
                    exp_test = exp_test_q.pop_front();
                    exp_cycle = exp_cycle_q.pop_front();
                    test_seen[exp_test]++;
                    if (cycle_count != exp_cycle) begin
                        $display("output beat %0d came at cycle %0d instead of cycle %0d",
                                 n_seen, cycle_count, exp_cycle);
                        n_errors++;
                        test_errors[exp_test]++;
                    end
                    if (out_data !== exp_data) begin
                        $display("** Error: out_data beat %0d expected %h got %h",
                                 n_seen, exp_data, out_data);
                        n_errors++;
                        test_errors[exp_test]++;
                    end
                    if (out_last !== exp_last) begin
                        $display("** Error: out_last beat %0d expected %h got %h",
                                 n_seen, exp_last, out_last);
                        n_errors++;
                        test_errors[exp_test]++;
                    end
                    n_seen++;
                end
            end else if (out_last !== 1'b0) begin
                $display("out_last was high while out_valid was low");
                n_errors++;
                test_errors[int'(cur_test)]++;
            end
            cycle_count++;
        end
    end

    always @(posedge report_now) begin
        for (int t = 1; t <= NUM_TESTS; t++) begin
            $display("test %0d %s: %0d of %0d beats, %0d errors, %s", t, test_name[t],
                     test_seen[t], test_expected[t], test_errors[t],
                     (test_errors[t] == 0 && test_seen[t] == test_expected[t]) ? "ok" : "bad");
        end
        $display("checked %0d of %0d beats with %0d errors", n_seen, n_expected, n_errors);
    end

endmodule

// ==== tb/tb_quant.sv ====
`timescale 1ns/1ps

module tb_quant;
    import quant_pkg::*;

    localparam int REC_WORDS     = 7;
    localparam int MAX_RECS      = 64;
    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 4;
    localparam int DRAIN_TIMEOUT = 50;

    logic         clk;
    logic         rst_n;
    sf_exp_t      sf_exp;
    sf_man_t      sf_man;
    quant_mode_t  quant_mode;
    in_beat_t     in_data;
    logic         in_valid;
    logic         in_last;
    out_beat_t    out_data;
    logic         out_valid;
    logic         out_last;
    logic [3:0]   cur_test;
    logic         report_now;
    int           beats_expected;
    int           beats_seen;
    int           error_count;
    logic         timed_out;
    int           wait_cycles;
    int           rec;
    logic [127:0] vec_mem [0:REC_WORDS*MAX_RECS-1];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    dm_quant_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sf_exp    (sf_exp),
        .sf_man    (sf_man),
        .quant_mode(quant_mode),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    quant_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .out_last      (out_last),
        .cur_test      (cur_test),
        .report_now    (report_now),
        .beats_expected(beats_expected),
        .beats_seen    (beats_seen),
        .error_count   (error_count)
    );

    // one line of the vector file becomes one cycle of DUT inputs
    task automatic apply_record(input int r);
        logic [127:0] ctrl;
        ctrl = vec_mem[r*REC_WORDS];
        cur_test   <= ctrl[39:36];
        quant_mode <= quant_mode_t'(ctrl[33:32]);
        sf_exp     <= ctrl[28:24];
        sf_man     <= ctrl[23:8];
        in_valid   <= ctrl[4];
        in_last    <= ctrl[0];
        in_data    <= {vec_mem[r*REC_WORDS+1], vec_mem[r*REC_WORDS+2],
                       vec_mem[r*REC_WORDS+3], vec_mem[r*REC_WORDS+4]};
    endtask

    initial begin
        rst_n      = 1'b0;
        sf_exp     = '0;
        sf_man     = '0;
        quant_mode = mode_int8_int8;
        in_data    = '0;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        cur_test   = 4'd1;
        report_now = 1'b0;
        timed_out  = 1'b0;
        $readmemh("tb/quant_vectors.txt", vec_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        rec = 0;
        while (rec < MAX_RECS && vec_mem[rec*REC_WORDS][39:36] != 4'd0) begin
            @(posedge clk);
            apply_record(rec);
            rec++;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_last  <= 1'b0;

        wait_cycles = 0;
        while (beats_seen < beats_expected && wait_cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (beats_seen < beats_expected) begin
            $display("timeout while draining, %0d output beats are missing",
                     beats_expected - beats_seen);
            timed_out = 1'b1;
        end

        report_now = 1'b1;
        #1;
        if (error_count == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // overall limit in case the drive loop itself stalls
    initial begin
        #(CLK_PERIOD*2000);
        $display("simulation ran past its time limit");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== tb/quant_vectors.txt ====
// ctrl: test, mode, sf_exp (2 digits), sf_man (4 digits), valid, last
// then in_data as four 128-bit words from the top, expected out_data as two from the top
1000000100 0 0 0 0 0 0
1000000100 0 0 0 0 0 0
1000000100 0 0 0 0 0 0
1000000100 0 0 0 0 0 0
2000000110 ffff0001ffff0001ffff0001ffff0001 0100007f0100007f0100007f0100007f 0012fffe0012fffe0012fffe0012fffe 7fff80007fff80007fff80007fff8000 ff01ff01ff01ff01007f007f007f007f 12fe12fe12fe12feff00ff00ff00ff00
2000000111 00400020004000200040002000400020 00400020004000200040002000400020 00400020004000200040002000400020 00400020004000200040002000400020 40204020402040204020402040204020 40204020402040204020402040204020
2000000100 0 0 0 0 0 0
2000000100 0 0 0 0 0 0
2000000100 0 0 0 0 0 0
2000000100 0 0 0 0 0 0
2000000100 0 0 0 0 0 0
201fffff11 12340000123400001234000012340000 0000ffff0000ffff0000ffff0000ffff ffff0001ffff0001ffff0001ffff0001 7fff80007fff80007fff80007fff8000 000000000000000000ff00ff00ff00ff ff00ff00ff00ff0000ff00ff00ff00ff
201fffff10 0 0 0 0 0 0
201fffff10 0 0 0 0 0 0
201fffff10 0 0 0 0 0 0
201fffff10 0 0 0 0 0 0
201fffff10 0 0 0 0 0 0
3202000310 00008040000080400000804000008040 ffff007fffff007fffff007fffff007f 1234bc051234bc051234bc051234bc05 abcd3c00abcd3c00abcd3c00abcd3c00 0 70707070bfbfbfbf9c9c9c9c60606060
3202000311 5555c0005555c0005555c0005555c000 5555c0005555c0005555c0005555c000 5555c0005555c0005555c0005555c000 5555c0005555c0005555c0005555c000 0 a0a0a0a0a0a0a0a0a0a0a0a0a0a0a0a0
3202000300 0 0 0 0 0 0
3202000300 0 0 0 0 0 0
3202000300 0 0 0 0 0 0
3202000300 0 0 0 0 0 0
3202000300 0 0 0 0 0 0
4300000110 4444dddd4444dddd4444dddd4444dddd 3333cccc3333cccc3333cccc3333cccc 2222bbbb2222bbbb2222bbbb2222bbbb 1111aaaa1111aaaa1111aaaa1111aaaa ddddddddddddddddcccccccccccccccc bbbbbbbbbbbbbbbbaaaaaaaaaaaaaaaa
4300000100 0 0 0 0 0 0
4300000110 ffff3c00ffff3c00ffff3c00ffff3c00 ffff3c00ffff3c00ffff3c00ffff3c00 ffff3c00ffff3c00ffff3c00ffff3c00 ffff3c00ffff3c00ffff3c00ffff3c00 3c003c003c003c003c003c003c003c00 3c003c003c003c003c003c003c003c00
4300000100 0 0 0 0 0 0
4300000111 0000c1230000c1230000c1230000c123 0000c1230000c1230000c1230000c123 0000c1230000c1230000c1230000c123 0000c1230000c1230000c1230000c123 c123c123c123c123c123c123c123c123 c123c123c123c123c123c123c123c123
4300000100 0 0 0 0 0 0
4300000100 0 0 0 0 0 0
4300000100 0 0 0 0 0 0
4300000100 0 0 0 0 0 0
4300000100 0 0 0 0 0 0
5004000310 00200100002001000020010000200100 00200100002001000020010000200100 00200100002001000020010000200100 00200100002001000020010000200100 06300630063006300630063006300630 06300630063006300630063006300630
5004000310 ffe0ff00ffe0ff00ffe0ff00ffe0ff00 ffe0ff00ffe0ff00ffe0ff00ffe0ff00 ffe0ff00ffe0ff00ffe0ff00ffe0ff00 ffe0ff00ffe0ff00ffe0ff00ffe0ff00 fad0fad0fad0fad0fad0fad0fad0fad0 fad0fad0fad0fad0fad0fad0fad0fad0
5004000311 10000007100000071000000710000007 10000007100000071000000710000007 10000007100000071000000710000007 10000007100000071000000710000007 00010001000100010001000100010001 00010001000100010001000100010001
5004000300 0 0 0 0 0 0
5004000300 0 0 0 0 0 0
5004000300 0 0 0 0 0 0
5004000300 0 0 0 0 0 0
5004000300 0 0 0 0 0 0
6100000110 00400020004000200040002000400020 00400020004000200040002000400020 00400020004000200040002000400020 00400020004000200040002000400020 0 0
6100000111 7fff80007fff80007fff80007fff8000 7fff80007fff80007fff80007fff8000 7fff80007fff80007fff80007fff8000 7fff80007fff80007fff80007fff8000 0 0
6100000100 0 0 0 0 0 0
6100000100 0 0 0 0 0 0
6100000100 0 0 0 0 0 0
6100000100 0 0 0 0 0 0
6100000100 0 0 0 0 0 0

// ==== project.f ====
+incdir+verilog
verilog/quant_pkg.sv
verilog/lane_scaler.sv
verilog/scale_array.sv
verilog/quant_output_stage.sv
verilog/dm_quant_top.sv
tb/quant_checker.sv
tb/tb_quant.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_quant
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
